// ==== bench/mem_words.svh ====
// one xorshift32 step, also used for the stall pattern
function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
endfunction

// instruction word at byte address a, every address bit counts
function automatic logic [31:0] mem_word(input logic [31:0] a);
    return xorshift32(xorshift32(a ^ 32'h2987));
endfunction

// ==== bench/fetch_tb.sv ====
`include "icache_settings.svh"

module fetch_tb
    import mem_pkg::*;
    import icache_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int TOTAL_INSTRS = 102;                     // 32 + 16 + 6 + 24 + 16 + 8
    localparam int WATCH_CYCLES = TOTAL_INSTRS * 40 + 400; // margin for settling and reg access

    `include "mem_words.svh"

    logic             clock;
    logic             reset;
    logic             stall;
    logic             redirect;
    logic [`XLEN-1:0] target_pc;
    logic [`XLEN-1:0] instr;
    logic [`XLEN-1:0] instr_pc;
    logic             instr_valid;
    logic             reg_write;
    cfg_reg_e         reg_addr;
    logic [`XLEN-1:0] reg_wdata;
    logic [`XLEN-1:0] reg_rdata;
    mem_cmd_e         mem_command;
    logic [`XLEN-1:0] mem_addr;
    mem_tag_t         mem_response;
    logic             mem_response_valid;
    mem_block_t       mem_data;
    mem_tag_t         mem_data_tag;

    logic [`XLEN-1:0] expected_pc;                 // next pc due on instr_valid
    logic             redirect_seen;               // redirect at the last edge
    logic [`XLEN-1:0] target_seen;
    logic [31:0]      stall_state = 32'h2987;
    int               received    = 0;             // instructions checked
    string            test_name   = "reset";

    fetch_top UUT (
        .clock              (clock),
        .reset              (reset),
        .stall              (stall),
        .redirect           (redirect),
        .target_pc          (target_pc),
        .instr              (instr),
        .instr_pc           (instr_pc),
        .instr_valid        (instr_valid),
        .reg_write          (reg_write),
        .reg_addr           (reg_addr),
        .reg_wdata          (reg_wdata),
        .reg_rdata          (reg_rdata),
        .mem_command        (mem_command),
        .mem_addr           (mem_addr),
        .mem_response       (mem_response),
        .mem_response_valid (mem_response_valid),
        .mem_data           (mem_data),
        .mem_data_tag       (mem_data_tag)
    );

    mem_model memory (
        .clock          (clock),
        .reset          (reset),
        .command        (mem_command),
        .addr           (mem_addr),
        .response       (mem_response),
        .response_valid (mem_response_valid),
        .data           (mem_data),
        .data_tag       (mem_data_tag)
    );

    always #4 clock = ~clock; // 8 ns period

    task automatic stop_with_failure(input string what);
        $display("%s", what);
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string field, input logic [31:0] expected,
                                   input logic [31:0] actual);
        stop_with_failure($sformatf("Error in %s: %s expected %h, actual %h",
                                    test_name, field, expected, actual));
    endtask

    // pc after one edge where redirect beats advance
    function automatic logic [`XLEN-1:0] next_pc(input logic [`XLEN-1:0] pc,
                                                 input logic redirected,
                                                 input logic [`XLEN-1:0] target,
                                                 input logic taken);
        if (redirected)
            return target;
        return taken ? pc + 32'd4 : pc;
    endfunction

    always @(posedge clock) begin
        redirect_seen <= redirect;
        target_seen   <= target_pc;
    end

    // each delivered word must be the next pc in program order
    always @(negedge clock) begin
        if (reset) begin
            expected_pc = `RESET_PC;
        end else begin
            if (instr_valid) begin
                assert (instr_pc == expected_pc)
                    else report_mismatch("instr_pc", expected_pc, instr_pc);
                assert (instr == mem_word(expected_pc))
                    else report_mismatch("instr", mem_word(expected_pc), instr);
                received++;
            end
            expected_pc = next_pc(expected_pc, redirect_seen, target_seen, instr_valid);
        end
    end

    task automatic settle(input int cycles);
        repeat (cycles) @(negedge clock);
    endtask

    // run until n words are out and then park the pc under stall
    task automatic fetch_count(input int n, input bit random_stall);
        int got;
        got   = 0;
        stall = 1'b0;
        while (got < n) begin
            @(negedge clock);
            if (instr_valid)
                got++;
            if (got < n && random_stall) begin
                stall_state = xorshift32(stall_state);
                stall       = stall_state[4];
            end else if (got < n) begin
                stall = 1'b0;
            end
        end
        stall = 1'b1;
    endtask

    task automatic redirect_to(input logic [`XLEN-1:0] target);
        redirect  = 1'b1;
        target_pc = target;
        @(negedge clock);
        redirect  = 1'b0;
    endtask

    task automatic write_reg(input cfg_reg_e addr, input logic [31:0] value);
        reg_write = 1'b1;
        reg_addr  = addr;
        reg_wdata = value;
        @(negedge clock);
        reg_write = 1'b0;
    endtask

    task automatic read_reg(input cfg_reg_e addr, output logic [31:0] value);
        reg_addr = addr;
        #1 value = reg_rdata; // sampled in the low phase
        @(negedge clock);
    endtask

    task automatic expect_reg(input cfg_reg_e addr, input logic [31:0] expected);
        logic [31:0] value;
        read_reg(addr, value);
        assert (value == expected) else report_mismatch(addr.name(), expected, value);
    endtask

    initial begin
        logic [31:0] hits;
        logic [31:0] misses;
        clock     = 1'b0;
        reset     = 1'b1;
        stall     = 1'b1;
        redirect  = 1'b0;
        target_pc = '0;
        reg_write = 1'b0;
        reg_addr  = REG_CTRL;
        reg_wdata = '0;
        repeat (3) @(negedge clock);
        reset = 1'b0;

        test_name = "straight line";
        fetch_count(32, 1'b0);
        settle(12);
        expect_reg(REG_MISS_COUNT, 32'd17); // blocks 0..15 plus block 16 of the parked pc
        expect_reg(REG_HIT_COUNT, 32'd0);

        test_name = "loop";
        for (int i = 1; i <= 2; i++) begin
            redirect_to(32'h40);
            fetch_count(8, 1'b0);
            settle(4);
            expect_reg(REG_HIT_COUNT, 5 * i); // 4 loop blocks plus parked block 12
        end
        expect_reg(REG_MISS_COUNT, 32'd17);

        test_name = "redirect";
        redirect_to(32'h2000);
        settle(2);               // tag taken while the block is still in flight
        redirect_to(32'h3040);
        fetch_count(6, 1'b0);

        test_name = "random stall";
        fetch_count(24, 1'b1);

        test_name = "flush";
        redirect_to(32'h40);
        fetch_count(8, 1'b0);
        settle(12);
        read_reg(REG_MISS_COUNT, misses);
        write_reg(REG_FLUSH, 32'd1);
        settle(12);              // parked block reloads
        redirect_to(32'h40);
        fetch_count(8, 1'b0);
        settle(12);
        expect_reg(REG_MISS_COUNT, misses + 32'd5); // parked reload + 4 loop blocks

        test_name = "disabled";
        write_reg(REG_CTRL, 32'd0);
        read_reg(REG_HIT_COUNT, hits);
        redirect_to(32'h40);
        fetch_count(8, 1'b0);
        settle(12);
        expect_reg(REG_HIT_COUNT, hits);
        expect_reg(REG_CTRL, 32'd0);

        test_name = "summary";
        assert (received == TOTAL_INSTRS) begin
            $display("Done: no errors");
            $finish;
        end else begin
            report_mismatch("instruction count", TOTAL_INSTRS, received);
        end
    end

    initial begin
        repeat (WATCH_CYCLES) @(posedge clock);
        stop_with_failure($sformatf("Watchdog expired: fetch stalled without producing %s",
                                    $sformatf("instructions, %0d checked", received)));
    end

endmodule

// ==== bench/mem_model.sv ====
`include "icache_settings.svh"

module mem_model
    import mem_pkg::*;
(
    input  logic             clock,
    input  logic             reset,
    input  mem_cmd_e         command,
    input  logic [`XLEN-1:0] addr,
    output mem_tag_t         response,
    output logic             response_valid,
    output mem_block_t       data,
    output mem_tag_t         data_tag
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int LATENCY = 4; // edges from load to data

    `include "mem_words.svh"

    mem_tag_t         next_tag;            // tag for the next load, 1..15
    mem_tag_t         pipe_tag  [LATENCY]; // 0 = empty slot
    logic [`XLEN-1:0] pipe_addr [LATENCY];
    logic             load;

    assign load           = (command == MEM_LOAD);
    assign response_valid = load;                  // answered in the same cycle
    assign response       = load ? next_tag : '0;

    always @(posedge clock) begin
        if (reset) begin
            next_tag <= 1;
            for (int i = 0; i < LATENCY; i++) begin
                pipe_tag[i]  <= '0;
                pipe_addr[i] <= '0;
            end
        end else begin
            case (command)
                MEM_LOAD:  next_tag <= (next_tag == '1) ? mem_tag_t'(1) : next_tag + 1'b1;
                MEM_STORE: ; // nothing stores into instruction memory
                default:   ;
            endcase
            pipe_tag[0]  <= load ? next_tag : '0;
            pipe_addr[0] <= {addr[`XLEN-1:3], 3'b000};
            for (int i = 1; i < LATENCY; i++) begin
                pipe_tag[i]  <= pipe_tag[i-1];
                pipe_addr[i] <= pipe_addr[i-1];
            end
        end
    end

    // block shows for one cycle with its tag
    assign data_tag = pipe_tag[LATENCY-1];

    always_comb begin
        data.words[0] = mem_word(pipe_addr[LATENCY-1]);
        data.words[1] = mem_word(pipe_addr[LATENCY-1] + 32'd4); // upper word
    end

endmodule

// ==== fetch_sub.f ====
+incdir+verilog
+incdir+bench
verilog/mem_pkg.sv
verilog/icache_pkg.sv
verilog/mem_bus_if.sv
verilog/icache_cfg_if.sv
verilog/icache.sv
verilog/icache_regs.sv
verilog/fetch_unit.sv
verilog/fetch_top.sv
bench/mem_model.sv
bench/fetch_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module fetch_tb -f fetch_sub.f
./obj_dir/Vfetch_tb 2>&1 | tee sim.log

if grep -q "Done: errors found" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"

// ==== verilog/fetch_top.sv ====
`include "icache_settings.svh"

module fetch_top
    import mem_pkg::*;
    import icache_pkg::*;
(
    input  logic             clock,
    input  logic             reset,
    input  logic             stall,
    input  logic             redirect,
    input  logic [`XLEN-1:0] target_pc,
    output logic [`XLEN-1:0] instr,
    output logic [`XLEN-1:0] instr_pc,
    output logic             instr_valid,
    input  logic             reg_write,
    input  cfg_reg_e         reg_addr,
    input  logic [`XLEN-1:0] reg_wdata,
    output logic [`XLEN-1:0] reg_rdata,
    output mem_cmd_e         mem_command,
    output logic [`XLEN-1:0] mem_addr,
    input  mem_tag_t         mem_response,
    input  logic             mem_response_valid,
    input  mem_block_t       mem_data,
    input  mem_tag_t         mem_data_tag
);

    logic [`XLEN-1:0] fetch_addr;
    logic [`XLEN-1:0] fetch_data;
    logic             fetch_valid;

    mem_bus_if    mem_bus ();
    icache_cfg_if cfg_bus ();

    // bus out to the pins
    assign mem_command            = mem_bus.command;
    assign mem_addr               = mem_bus.addr;
    assign mem_bus.response       = mem_response;
    assign mem_bus.response_valid = mem_response_valid;
    assign mem_bus.data           = mem_data;
    assign mem_bus.data_tag       = mem_data_tag;

    fetch_unit fetch (
        .clock       (clock),
        .reset       (reset),
        .stall       (stall),
        .redirect    (redirect),
        .target_pc   (target_pc),
        .fetch_addr  (fetch_addr),
        .fetch_data  (fetch_data),
        .fetch_valid (fetch_valid),
        .instr       (instr),
        .instr_pc    (instr_pc),
        .instr_valid (instr_valid)
    );

    icache cache (
        .clock       (clock),
        .reset       (reset),
        .fetch_addr  (fetch_addr),
        .fetch_data  (fetch_data),
        .fetch_valid (fetch_valid),
        .mem         (mem_bus.cache),
        .cfg         (cfg_bus.cache)
    );

    icache_regs regs (
        .clock     (clock),
        .reset     (reset),
        .reg_write (reg_write),
        .reg_addr  (reg_addr),
        .reg_wdata (reg_wdata),
        .reg_rdata (reg_rdata),
        .cfg       (cfg_bus.regs)
    );

endmodule

// ==== verilog/fetch_unit.sv ====
`include "icache_settings.svh"

module fetch_unit (
    input  logic             clock,
    input  logic             reset,
    input  logic             stall,
    input  logic             redirect,
    input  logic [`XLEN-1:0] target_pc,
    output logic [`XLEN-1:0] fetch_addr,
    input  logic [`XLEN-1:0] fetch_data,
    input  logic             fetch_valid,
    output logic [`XLEN-1:0] instr,
    output logic [`XLEN-1:0] instr_pc,
    output logic             instr_valid
);

    logic [`XLEN-1:0] pc;
    logic             accept;

    assign fetch_addr = pc;
    assign accept     = fetch_valid && !stall && !redirect; // word taken this edge

    // program counter, redirect wins over advance
    always_ff @(posedge clock) begin
        if (reset)
            pc <= `RESET_PC;
        else if (redirect)
            pc <= target_pc;
        else if (accept)
            pc <= pc + `XLEN'd4;
    end

    // one-cycle valid per accepted word
    always_ff @(posedge clock) begin
        if (reset)
            instr_valid <= 1'b0;
        else
            instr_valid <= accept; // drops under stall or redirect
    end

    // payload holds when nothing is accepted
    always_ff @(posedge clock) begin
        if (accept) begin
            instr    <= fetch_data;
            instr_pc <= pc;
        end
    end

endmodule

// ==== verilog/icache.sv ====
`include "icache_settings.svh"

module icache
    import mem_pkg::*;
    import icache_pkg::*;
(
    input  logic             clock,
    input  logic             reset,
    input  logic [`XLEN-1:0] fetch_addr,
    output logic [`XLEN-1:0] fetch_data,
    output logic             fetch_valid,
    mem_bus_if.cache         mem,
    icache_cfg_if.cache      cfg
);

    icache_line_t lines [`ICACHE_LINES];

    icache_addr_t      addr_f;            // fetch address split
    icache_line_t      line;              // selected line
    logic [`XLEN-4:0]  last_block;        // block seen last cycle
    logic              last_seen;         // last_block holds something
    mem_tag_t          wait_tag;          // tag of the pending block
    logic              miss_outstanding;  // load still being requested
    logic              load_issued;       // miss already counted
    logic              changed_addr;
    logic              lookup_hit;
    logic              tag_arrived;
    logic              bypass;
    logic              fill;
    logic              send_load;
    logic              unanswered_miss;

    assign addr_f = fetch_addr;
    assign line   = lines[addr_f.index];

    // only the block matters, word moves inside a block are not a change
    assign changed_addr = !last_seen || (fetch_addr[`XLEN-1:3] != last_block);

    assign lookup_hit  = cfg.enable && line.valid && (line.tag == addr_f.tag);
    assign tag_arrived = !changed_addr && (wait_tag != '0) && (mem.data_tag == wait_tag);
    assign bypass      = !cfg.enable && tag_arrived; // pass through, no write
    assign fill        = cfg.enable && tag_arrived;

    assign fetch_valid = lookup_hit || bypass;
    assign fetch_data  = bypass ? mem.data.words[addr_f.offset[2]]
                                : line.data.words[addr_f.offset[2]];

    assign send_load   = miss_outstanding && !changed_addr;
    assign mem.command = send_load ? MEM_LOAD : MEM_NONE;
    assign mem.addr    = {fetch_addr[`XLEN-1:3], 3'b000};

    // new block: miss if not present
    // requesting: keep on until a tag comes back
    // same block, nothing pending and no hit (flushed or bypassed): ask again
    always_comb begin
        if (changed_addr)
            unanswered_miss = !lookup_hit;
        else if (miss_outstanding)
            unanswered_miss = !mem.response_valid || (mem.response == '0);
        else
            unanswered_miss = !lookup_hit && (wait_tag == '0);
    end

    assign cfg.hit_event  = changed_addr && lookup_hit;
    assign cfg.miss_event = send_load && !load_issued;

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `ICACHE_LINES; i++) begin
                lines[i].valid <= 1'b0;
            end
            miss_outstanding <= 1'b0;
            load_issued      <= 1'b0;
            last_seen        <= 1'b0;
            last_block       <= '0;
            wait_tag         <= '0;
        end else begin
            miss_outstanding <= unanswered_miss;
            last_seen        <= 1'b1;
            last_block       <= fetch_addr[`XLEN-1:3];

            if (changed_addr || cfg.flush)
                load_issued <= 1'b0;
            else if (send_load)
                load_issued <= 1'b1;

            if (changed_addr)
                wait_tag <= '0; // late data for the old block is dropped
            else if (miss_outstanding)
                wait_tag <= mem.response_valid ? mem.response : '0;
            else if (tag_arrived)
                wait_tag <= '0; // block delivered

            if (cfg.flush) begin
                for (int i = 0; i < `ICACHE_LINES; i++) begin
                    lines[i].valid <= 1'b0;
                end
            end

            // fill after flush so the block just returned survives
            if (fill) begin
                lines[addr_f.index].tag   <= addr_f.tag;
                lines[addr_f.index].valid <= 1'b1;
                lines[addr_f.index].data  <= mem.data;
            end
        end
    end

endmodule

// ==== verilog/icache_cfg_if.sv ====
interface icache_cfg_if;

    logic enable;     // level, cache lookups allowed
    logic flush;      // one-cycle pulse
    logic hit_event;  // new line hit
    logic miss_event; // first load for a line

    modport regs (
        output enable,
        output flush,
        input  hit_event,
        input  miss_event
    );

    modport cache (
        input  enable,
        input  flush,
        output hit_event,
        output miss_event
    );

endinterface

// ==== verilog/icache_pkg.sv ====
`include "icache_settings.svh"

package icache_pkg;

    import mem_pkg::*;

    localparam int INDEX_BITS  = $clog2(`ICACHE_LINES); // 5 for 32 lines
    localparam int OFFSET_BITS = 3;                     // 8-byte block

    // full address split for the direct-mapped lookup
    typedef struct packed {
        logic [`ICACHE_TAG_BITS-1:0] tag;
        logic [INDEX_BITS-1:0]       index;
        logic [OFFSET_BITS-1:0]      offset;
    } icache_addr_t;

    // one cache line
    typedef struct packed {
        logic [`ICACHE_TAG_BITS-1:0] tag;
        logic                        valid;
        mem_block_t                  data;
    } icache_line_t;

    // register map of the config block
    typedef enum logic [1:0] {
        REG_CTRL       = 2'd0, // bit 0 = enable
        REG_FLUSH      = 2'd1, // any write flushes
        REG_HIT_COUNT  = 2'd2,
        REG_MISS_COUNT = 2'd3
    } cfg_reg_e;

endpackage

// ==== verilog/icache_regs.sv ====
`include "icache_settings.svh"

module icache_regs
    import icache_pkg::*;
(
    input  logic             clock,
    input  logic             reset,
    input  logic             reg_write,
    input  cfg_reg_e         reg_addr,
    input  logic [`XLEN-1:0] reg_wdata,
    output logic [`XLEN-1:0] reg_rdata,
    icache_cfg_if.regs       cfg
);

    logic             enable;
    logic             flush;
    logic [`XLEN-1:0] hit_count;
    logic [`XLEN-1:0] miss_count;

    assign cfg.enable = enable;
    assign cfg.flush  = flush;

    always_ff @(posedge clock) begin
        if (reset) begin
            enable     <= 1'b1; // cache on out of reset
            flush      <= 1'b0;
            hit_count  <= '0;
            miss_count <= '0;
        end else begin
            flush <= reg_write && (reg_addr == REG_FLUSH); // one cycle only

            if (reg_write && (reg_addr == REG_CTRL))
                enable <= reg_wdata[0];

            // write clears, otherwise count and stick at all ones
            if (reg_write && (reg_addr == REG_HIT_COUNT))
                hit_count <= '0;
            else if (cfg.hit_event && (hit_count != '1))
                hit_count <= hit_count + 1'b1;

            if (reg_write && (reg_addr == REG_MISS_COUNT))
                miss_count <= '0;
            else if (cfg.miss_event && (miss_count != '1))
                miss_count <= miss_count + 1'b1;
        end
    end

    always_comb begin
        case (reg_addr)
            REG_CTRL:       reg_rdata = {{(`XLEN-1){1'b0}}, enable};
            REG_FLUSH:      reg_rdata = '0; // write-only command
            REG_HIT_COUNT:  reg_rdata = hit_count;
            REG_MISS_COUNT: reg_rdata = miss_count;
            default:        reg_rdata = '0;
        endcase
    end

endmodule

// ==== verilog/icache_settings.svh ====
`ifndef ICACHE_SETTINGS_SVH
`define ICACHE_SETTINGS_SVH

// address and instruction width
`define XLEN 32

// direct-mapped, 8-byte blocks
`define ICACHE_LINES 32

// tag is what is left of XLEN above index and offset
`define ICACHE_TAG_BITS 24

// memory transaction tag, zero means no transaction
`define MEM_TAG_BITS 4

// first fetch address after reset
`define RESET_PC 32'h0000_0000

`endif

// ==== verilog/mem_bus_if.sv ====
`include "icache_settings.svh"

interface mem_bus_if
    import mem_pkg::*;
();

    mem_cmd_e          command;        // none or load from the cache
    logic [`XLEN-1:0]  addr;           // block aligned
    mem_tag_t          response;       // tag handed out for a load
    logic              response_valid;
    mem_block_t        data;           // returned block
    mem_tag_t          data_tag;       // tag of the returned block, 0 = idle

    modport cache (
        output command,
        output addr,
        input  response,
        input  response_valid,
        input  data,
        input  data_tag
    );

    modport memory (
        input  command,
        input  addr,
        output response,
        output response_valid,
        output data,
        output data_tag
    );

endinterface

// ==== verilog/mem_pkg.sv ====
`include "icache_settings.svh"

package mem_pkg;

    // bus command, store is decoded by memory only
    typedef enum logic [1:0] {
        MEM_NONE  = 2'd0,
        MEM_LOAD  = 2'd1,
        MEM_STORE = 2'd2
    } mem_cmd_e;

    typedef logic [`MEM_TAG_BITS-1:0] mem_tag_t; // 0 = idle

    // one 8-byte block, several views
    typedef union packed {
        logic [63:0]      double;
        logic [1:0][31:0] words;  // words[1] is the upper word
        logic [3:0][15:0] halves;
        logic [7:0][7:0]  bytes;
    } mem_block_t;

endpackage
